/* frame_pkg.sv */
/*
 * Frame transmitter shared types
 * Link byte, step and source types, frame constants and the header byte rule
 */
`default_nettype none

package frame_pkg;

    // ==================================================
    // Widths with a meaning
    // ==================================================
    typedef logic [7:0] byte_t;
    typedef logic [7:0] step_t;
    typedef logic [7:0] ins_len_t;

    typedef enum logic {SRC_INS, SRC_KEY} source_e;

    typedef enum logic [1:0] {IDLE, ARBIT, SEND} arb_state_e;

    // Key FIFO word, flag in the top bit
    typedef struct packed {
        logic        key_flag;
        logic [63:0] key_time;
        logic [15:0] key_code;
    } key_word_t;

    typedef struct packed {
        logic  valid;
        byte_t data;
    } link_byte_t;

    // ==================================================
    // Frame layout
    // ==================================================
    localparam int    HDR_BYTES       = 10;
    localparam int    TIME_BYTES      = 8;
    localparam int    LEN_FIELD_EXTRA = 6;
    localparam int    KEY_FRAME_BYTES = 22;
    localparam byte_t TYPE_INS        = 8'h02;
    localparam byte_t TYPE_KEY        = 8'h01;

    // Header is zero apart from the length field and the type code
    function automatic byte_t frame_header_byte(input step_t step, input byte_t len_field,
                                                input byte_t type_code);
        case (step)
            8'd3:    return len_field;
            8'd9:    return type_code;
            default: return 8'h00;
        endcase
    endfunction

endpackage

`default_nettype wire

/* frame_arbiter.sv */
/*
 * Frame arbiter
 * Alternates between the instruction and key sources and asks the link for a slot
 */
`default_nettype none

module frame_arbiter
(
    input  wire                clk_sys,
    input  wire                rst_n,
    input  wire                ins_empty,
    input  wire                key_empty,
    input  wire                frame_ack,
    input  wire                frame_done,
    output logic               frame_req,
    output logic               start,
    output frame_pkg::source_e grant
);
    import frame_pkg::*;

    arb_state_e state;
    source_e    pick;
    logic       src_waiting;

    assign src_waiting = !ins_empty || !key_empty;

    // Grant holds the last served source, so both waiting means switch
    always_comb
    begin
        if (!ins_empty && !key_empty)
            pick = (grant == SRC_INS) ? SRC_KEY : SRC_INS;
        else if (!ins_empty)
            pick = SRC_INS;
        else
            pick = SRC_KEY;
    end

    // ==================================================
    // State machine and link request
    // ==================================================
    // Grant comes out of reset as KEY so the first tie goes to INS
    always_ff @(posedge clk_sys or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= IDLE;
            frame_req <= 1'b0;
            start     <= 1'b0;
            grant     <= SRC_KEY;
        end
        else
        begin
            start <= 1'b0;
            case (state)
                IDLE:
                    state <= ARBIT;
                ARBIT:
                    if (src_waiting)
                    begin
                        grant     <= pick;
                        frame_req <= 1'b1;
                        state     <= SEND;
                    end
                SEND:
                begin
                    // Slot granted, hand over to the sequencer
                    if (frame_req && frame_ack)
                    begin
                        frame_req <= 1'b0;
                        start     <= 1'b1;
                    end
                    if (frame_done)
                        state <= IDLE;
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* frame_sequencer.sv */
/*
 * Frame sequencer
 * Steps through one frame, registers the link bytes and pops the served FIFO
 */
`default_nettype none

module frame_sequencer
(
    input  wire                     clk_sys,
    input  wire                     rst_n,
    input  wire                     start,
    input  wire frame_pkg::source_e grant,
    input  wire frame_pkg::ins_len_t cfg_ins_len,
    input  wire frame_pkg::byte_t   ins_byte,
    input  wire frame_pkg::byte_t   key_byte,
    output frame_pkg::step_t        step,
    output frame_pkg::link_byte_t   frame_out,
    output logic                    frame_done,
    output logic                    ins_pop,
    output logic                    key_pop
);
    import frame_pkg::*;

    logic  active;
    step_t last_step;
    byte_t sel_byte;
    logic  frame_end;

    assign sel_byte = (grant == SRC_INS) ? ins_byte : key_byte;

    // Last byte is on the link and no step is running
    assign frame_end = frame_out.valid && !active;

    // ==================================================
    // Step counter
    // ==================================================
    always_ff @(posedge clk_sys or negedge rst_n)
    begin
        if (!rst_n)
        begin
            active    <= 1'b0;
            step      <= '0;
            last_step <= '0;
        end
        else if (start)
        begin
            active <= 1'b1;
            step   <= '0;
            // Frame length minus one, header and time stamp included
            if (grant == SRC_INS)
                last_step <= cfg_ins_len + step_t'(HDR_BYTES + TIME_BYTES - 1);
            else
                last_step <= step_t'(KEY_FRAME_BYTES - 1);
        end
        else if (active)
        begin
            if (step == last_step)
            begin
                active <= 1'b0;
                step   <= '0;
            end
            else
            begin
                step <= step + 8'd1;
            end
        end
    end

    // ==================================================
    // Link byte and end of frame pulses
    // ==================================================
    always_ff @(posedge clk_sys or negedge rst_n)
    begin
        if (!rst_n)
        begin
            frame_out  <= '0;
            frame_done <= 1'b0;
            ins_pop    <= 1'b0;
            key_pop    <= 1'b0;
        end
        else
        begin
            frame_out.valid <= active;
            frame_out.data  <= active ? sel_byte : 8'h00;
            frame_done      <= frame_end;
            ins_pop         <= frame_end && (grant == SRC_INS);
            key_pop         <= frame_end && (grant == SRC_KEY);
        end
    end

endmodule

`default_nettype wire

/* ins_frame_builder.sv */
/*
 * Instruction frame builder
 * Header byte or instruction word byte for the current step
 */
`default_nettype none

module ins_frame_builder
#(
    parameter int INS_WORD_BYTES = 72
)
(
    input  wire frame_pkg::step_t                        step,
    input  wire frame_pkg::ins_len_t                     cfg_ins_len,
    input  wire frame_pkg::byte_t [INS_WORD_BYTES-1:0]   ins_word,
    output frame_pkg::byte_t                             ins_byte
);
    import frame_pkg::*;

    byte_t len_field;
    int    word_idx;

    // Frame bytes plus the fixed extra of the length field
    assign len_field = cfg_ins_len + byte_t'(HDR_BYTES + TIME_BYTES + LEN_FIELD_EXTRA);

    // Step 10 reads the top byte, later steps walk down the word
    assign word_idx = INS_WORD_BYTES - 1 + HDR_BYTES - int'(step);

    always_comb
    begin
        if (step < step_t'(HDR_BYTES))
            ins_byte = frame_header_byte(step, len_field, TYPE_INS);
        else if (word_idx >= 0)
            ins_byte = ins_word[word_idx];
        else
            ins_byte = 8'h00;
    end

endmodule

`default_nettype wire

/* key_frame_builder.sv */
/*
 * Key frame builder
 * Header byte, time stamp, flag or key code byte for the current step
 */
`default_nettype none

module key_frame_builder
(
    input  wire frame_pkg::step_t     step,
    input  wire frame_pkg::key_word_t key_word,
    output frame_pkg::byte_t          key_byte
);
    import frame_pkg::*;

    localparam byte_t KEY_LEN_FIELD = byte_t'(KEY_FRAME_BYTES + LEN_FIELD_EXTRA);

    logic [2:0] time_idx;

    // Time stamp goes out most significant byte first
    assign time_idx = 3'(step_t'(HDR_BYTES + TIME_BYTES - 1) - step);

    always_comb
    begin
        if (step < step_t'(HDR_BYTES))
            key_byte = frame_header_byte(step, KEY_LEN_FIELD, TYPE_KEY);
        else if (step < step_t'(HDR_BYTES + TIME_BYTES))
            key_byte = key_word.key_time[time_idx*8 +: 8];
        else
        begin
            // Tail is a spare zero, the flag, then the key code
            case (step)
                8'd18:   key_byte = 8'h00;
                8'd19:   key_byte = {7'b0, key_word.key_flag};
                8'd20:   key_byte = key_word.key_code[15:8];
                8'd21:   key_byte = key_word.key_code[7:0];
                default: key_byte = 8'h00;
            endcase
        end
    end

endmodule

`default_nettype wire

/* ins_frame_tx.sv */
/*
 * Instruction frame transmitter top
 * Frames instruction and key FIFO records for the host link
 */
`default_nettype none

module ins_frame_tx
#(
    parameter int INS_WORD_BYTES = 72
)
(
    input  wire                                        clk_sys,
    input  wire                                        rst_n,
    input  wire frame_pkg::byte_t [INS_WORD_BYTES-1:0] ins_word,
    input  wire                                        ins_empty,
    output logic                                       ins_pop,
    input  wire frame_pkg::key_word_t                  key_word,
    input  wire                                        key_empty,
    output logic                                       key_pop,
    input  wire frame_pkg::ins_len_t                   cfg_ins_len,
    output logic                                       frame_req,
    input  wire                                        frame_ack,
    output frame_pkg::link_byte_t                      frame_out,
    output logic                                       frame_done
);
    import frame_pkg::*;

    source_e grant;
    logic    start;
    step_t   step;
    byte_t   ins_byte;
    byte_t   key_byte;

    // ==================================================
    // Arbitration and link request
    // ==================================================
    frame_arbiter frame_arbiter_i (
        .clk_sys    (clk_sys),
        .rst_n      (rst_n),
        .ins_empty  (ins_empty),
        .key_empty  (key_empty),
        .frame_ack  (frame_ack),
        .frame_done (frame_done),
        .frame_req  (frame_req),
        .start      (start),
        .grant      (grant)
    );

    // ==================================================
    // Frame sequencing
    // ==================================================
    frame_sequencer frame_sequencer_i (
        .clk_sys     (clk_sys),
        .rst_n       (rst_n),
        .start       (start),
        .grant       (grant),
        .cfg_ins_len (cfg_ins_len),
        .ins_byte    (ins_byte),
        .key_byte    (key_byte),
        .step        (step),
        .frame_out   (frame_out),
        .frame_done  (frame_done),
        .ins_pop     (ins_pop),
        .key_pop     (key_pop)
    );

    // Byte builders, both follow the same step
    ins_frame_builder #(
        .INS_WORD_BYTES (INS_WORD_BYTES)
    ) ins_frame_builder_i (
        .step        (step),
        .cfg_ins_len (cfg_ins_len),
        .ins_word    (ins_word),
        .ins_byte    (ins_byte)
    );

    key_frame_builder key_frame_builder_i (
        .step     (step),
        .key_word (key_word),
        .key_byte (key_byte)
    );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
/*
 * Testbench clock and reset
 */
`default_nettype none

module tb_clock_gen
#(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 5
)
(
    output logic clk_sys,
    output logic rst_n
);
    initial
    begin
        clk_sys = 1'b0;
        rst_n   = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_sys);
        #(PERIOD / 10);
        rst_n = 1'b1;
    end

    always #(PERIOD / 2) clk_sys = ~clk_sys;

endmodule

`default_nettype wire

/* ins_frame_tx_assert.sv */
/*
 * Link protocol assertions for the frame transmitter
 */
`default_nettype none

module ins_frame_tx_assert
(
    input wire                        clk_sys,
    input wire                        rst_n,
    input wire                        frame_req,
    input wire                        frame_ack,
    input wire frame_pkg::link_byte_t frame_out,
    input wire                        ins_pop,
    input wire                        key_pop
);
    // No byte goes out while the link slot is still requested
    a_no_valid_in_req: assert property (@(posedge clk_sys) disable iff (!rst_n)
        frame_req |-> !frame_out.valid)
        else $error("frame_out.valid high while frame_req is high");

    a_req_drop_on_ack: assert property (@(posedge clk_sys) disable iff (!rst_n)
        $fell(frame_req) |-> $past(frame_ack))
        else $error("frame_req fell without frame_ack");

    a_single_pop: assert property (@(posedge clk_sys) disable iff (!rst_n)
        !(ins_pop && key_pop))
        else $error("ins_pop and key_pop high together");

endmodule

bind ins_frame_tx ins_frame_tx_assert ins_frame_tx_assert_i (
    .clk_sys   (clk_sys),
    .rst_n     (rst_n),
    .frame_req (frame_req),
    .frame_ack (frame_ack),
    .frame_out (frame_out),
    .ins_pop   (ins_pop),
    .key_pop   (key_pop)
);

`default_nettype wire

/* tb_ins_frame_tx.sv */
/*
 * Frame transmitter testbench
 * FIFO and link models driven from the trace file and frame byte checks
 */
`default_nettype none

module tb_ins_frame_tx;
    import frame_pkg::*;

    localparam int PERIOD         = 100;
    localparam int DRIVE_DLY      = 10;
    localparam int INS_WORD_BYTES = 72;
    localparam int MAX_REC        = 8;
    localparam int MAX_BYTES      = 32;
    localparam int RANDOM_DELAY   = 99;
    localparam int MARGIN         = 60;

    logic clk_sys;
    logic rst_n;
    logic [INS_WORD_BYTES*8-1:0] ins_word;
    logic       ins_empty;
    logic       ins_pop;
    key_word_t  key_word;
    logic       key_empty;
    logic       key_pop;
    ins_len_t   cfg_ins_len;
    logic       frame_req;
    logic       frame_ack;
    link_byte_t frame_out;
    logic       frame_done;

    // Trace records
    source_e      rec_src   [MAX_REC];
    logic [127:0] rec_word  [MAX_REC];
    ins_len_t     rec_len   [MAX_REC];
    int           rec_delay [MAX_REC];
    int           rec_load  [MAX_REC];
    int           rec_nb    [MAX_REC];
    byte_t        rec_bytes [MAX_REC][MAX_BYTES];
    int           num_rec;
    int           limit_cycles;
    logic         trace_loaded = 1'b0;
    integer       seed;

    int ins_q[$];
    int key_q[$];

    tb_clock_gen #(.PERIOD(PERIOD), .RST_CYCLES(5)) clock_gen_i (
        .clk_sys (clk_sys),
        .rst_n   (rst_n)
    );

    ins_frame_tx #(.INS_WORD_BYTES(INS_WORD_BYTES)) ins_frame_tx_i (
        .clk_sys     (clk_sys),
        .rst_n       (rst_n),
        .ins_word    (ins_word),
        .ins_empty   (ins_empty),
        .ins_pop     (ins_pop),
        .key_word    (key_word),
        .key_empty   (key_empty),
        .key_pop     (key_pop),
        .cfg_ins_len (cfg_ins_len),
        .frame_req   (frame_req),
        .frame_ack   (frame_ack),
        .frame_out   (frame_out),
        .frame_done  (frame_done)
    );

    // ==================================================
    // Failure reporting and compare tasks
    // ==================================================
    task automatic report_fail(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic compare_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp)
            report_fail($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic compare_source(input string name, input source_e got, input source_e exp);
        if (got !== exp)
            report_fail($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic compare_pulse(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_fail($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_link_idle();
        compare_pulse("frame_req", frame_req, 1'b0);
        compare_pulse("frame_out.valid", frame_out.valid, 1'b0);
        compare_pulse("frame_done", frame_done, 1'b0);
        compare_pulse("ins_pop", ins_pop, 1'b0);
        compare_pulse("key_pop", key_pop, 1'b0);
    endtask

    // ==================================================
    // Trace reader
    // ==================================================
    task automatic read_trace();
        int    fd;
        int    n;
        string tok;
        string line;
        logic [127:0] word;
        logic [7:0]   val;
        int    exp_nb;

        fd = $fopen("frame_trace.txt", "r");
        if (fd == 0)
            report_fail("cannot open frame_trace.txt");
        num_rec      = 0;
        limit_cycles = MARGIN;
        while ($fscanf(fd, "%s", tok) == 1)
        begin
            if (tok == "#")
            begin
                n = $fgets(line, fd);
            end
            else
            begin
                rec_src[num_rec] = (tok == "I") ? SRC_INS : SRC_KEY;
                n = $fscanf(fd, "%h %h %d %d %d", word, val, rec_delay[num_rec],
                            rec_load[num_rec], rec_nb[num_rec]);
                if (n != 5 || rec_nb[num_rec] > MAX_BYTES)
                    report_fail("malformed record in frame_trace.txt");
                rec_word[num_rec] = word;
                rec_len[num_rec]  = val;
                for (int i = 0; i < rec_nb[num_rec]; i++)
                begin
                    n = $fscanf(fd, "%h", val);
                    if (n != 1)
                        report_fail("missing frame byte in frame_trace.txt");
                    rec_bytes[num_rec][i] = val;
                end
                // Frame length is 18 plus the payload or 22 for a key record
                if (rec_src[num_rec] == SRC_INS)
                    exp_nb = int'(rec_len[num_rec]) + 18;
                else
                    exp_nb = KEY_FRAME_BYTES;
                if (rec_nb[num_rec] != exp_nb)
                    report_fail("trace record length does not match the frame rule");
                limit_cycles += rec_nb[num_rec] + rec_load[num_rec] + 12 +
                                ((rec_delay[num_rec] == RANDOM_DELAY) ? 8 : rec_delay[num_rec]);
                num_rec++;
            end
        end
        $fclose(fd);
    endtask

    // ==================================================
    // FIFO models
    // ==================================================
    task automatic drive_heads();
        ins_empty = (ins_q.size() == 0);
        key_empty = (key_q.size() == 0);
        ins_word  = '0;
        key_word  = '0;
        if (!ins_empty)
        begin
            ins_word    = {rec_word[ins_q[0]], {(INS_WORD_BYTES-16)*8{1'b0}}};
            cfg_ins_len = rec_len[ins_q[0]];
        end
        if (!key_empty)
            key_word = key_word_t'(rec_word[key_q[0]][80:0]);
    endtask

    initial
    begin
        int   cycle;
        logic ins_popped;
        logic key_popped;

        ins_empty   = 1'b1;
        key_empty   = 1'b1;
        ins_word    = '0;
        key_word    = '0;
        cfg_ins_len = '0;
        frame_ack   = 1'b0;
        cycle       = 0;
        wait (trace_loaded === 1'b1 && rst_n === 1'b1);
        forever
        begin
            @(negedge clk_sys);
            ins_popped = ins_pop;
            key_popped = key_pop;
            @(posedge clk_sys);
            #DRIVE_DLY;
            if (ins_popped && ins_q.size() > 0)
                void'(ins_q.pop_front());
            if (key_popped && key_q.size() > 0)
                void'(key_q.pop_front());
            for (int r = 0; r < num_rec; r++)
            begin
                if (rec_load[r] == cycle)
                begin
                    if (rec_src[r] == SRC_INS)
                        ins_q.push_back(r);
                    else
                        key_q.push_back(r);
                end
            end
            cycle++;
            drive_heads();
        end
    end

    // Watchdog
    initial
    begin
        wait (trace_loaded === 1'b1);
        repeat (limit_cycles) @(posedge clk_sys);
        report_fail("watchdog expired before all frames were sent");
    end

    // ==================================================
    // Link model and frame checks
    // ==================================================
    initial
    begin
        int      delay;
        source_e served;

        seed = 46378;
        read_trace();
        trace_loaded = 1'b1;

        // Outputs quiet through reset and just after
        @(negedge clk_sys);
        while (!rst_n)
        begin
            check_link_idle();
            @(negedge clk_sys);
        end
        check_link_idle();

        for (int f = 0; f < num_rec; f++)
        begin
            while (!frame_req)
            begin
                check_link_idle();
                @(negedge clk_sys);
            end
            delay = rec_delay[f];
            if (delay == RANDOM_DELAY)
                delay = int'($unsigned($random(seed)) % 6);
            repeat (delay)
            begin
                @(negedge clk_sys);
                compare_pulse("frame_req", frame_req, 1'b1);
                compare_pulse("frame_out.valid", frame_out.valid, 1'b0);
            end
            @(posedge clk_sys);
            #DRIVE_DLY;
            frame_ack = 1'b1;
            @(posedge clk_sys);
            #DRIVE_DLY;
            frame_ack = 1'b0;
            @(negedge clk_sys);
            compare_pulse("frame_req", frame_req, 1'b0);
            compare_pulse("frame_out.valid", frame_out.valid, 1'b0);
            @(negedge clk_sys);
            compare_pulse("frame_out.valid", frame_out.valid, 1'b0);
            // Bytes on consecutive cycles with no end pulses in between
            for (int b = 0; b < rec_nb[f]; b++)
            begin
                @(negedge clk_sys);
                compare_pulse("frame_out.valid", frame_out.valid, 1'b1);
                compare_byte($sformatf("frame_out.data[%0d]", b), frame_out.data,
                             rec_bytes[f][b]);
                compare_pulse("frame_done", frame_done, 1'b0);
                compare_pulse("ins_pop", ins_pop, 1'b0);
                compare_pulse("key_pop", key_pop, 1'b0);
            end
            @(negedge clk_sys);
            served = ins_pop ? SRC_INS : SRC_KEY;
            compare_pulse("frame_out.valid", frame_out.valid, 1'b0);
            compare_pulse("frame_done", frame_done, 1'b1);
            compare_source("served source", served, rec_src[f]);
            compare_pulse("ins_pop", ins_pop, rec_src[f] == SRC_INS);
            compare_pulse("key_pop", key_pop, rec_src[f] == SRC_KEY);
            @(negedge clk_sys);
            compare_pulse("frame_done", frame_done, 1'b0);
            compare_pulse("ins_pop", ins_pop, 1'b0);
            compare_pulse("key_pop", key_pop, 1'b0);
        end

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
frame_pkg.sv
frame_arbiter.sv
frame_sequencer.sv
ins_frame_builder.sv
key_frame_builder.sv
ins_frame_tx.sv
tb_clock_gen.sv
ins_frame_tx_assert.sv
tb_ins_frame_tx.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the frame transmitter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_ins_frame_tx -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi
exit 0

/* frame_trace.txt */
# src word_hex len_hex ack_delay(99 draws a random delay) load_cycle nbytes
# next line: expected frame bytes in hex, in link order
I 1011121314151617A0A1A2A3A4A5A6A7 04 0 0 22
00 00 00 1C 00 00 00 00 00 02 10 11 12 13 14 15 16 17 A0 A1 A2 A3
K 12021222324252627BEEF 00 3 0 22
00 00 00 1C 00 00 00 00 00 01 20 21 22 23 24 25 26 27 00 01 BE EF
I 3031323334353637C0C1C2C3C4C5C6C7 06 99 0 24
00 00 00 1E 00 00 00 00 00 02 30 31 32 33 34 35 36 37 C0 C1 C2 C3 C4 C5
K 040414243444546471234 00 2 30 22
00 00 00 1C 00 00 00 00 00 01 40 41 42 43 44 45 46 47 00 00 12 34
